// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dma_controller
FLIST     ?= dma_controller.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== core_trigger_writer.sv ====
module core_trigger_writer (
  input  logic                           clk,
  input  logic                           rst,
  trigger_if.writer                      trig,
  input  logic                           pkt_sent_to_core_valid,
  input  logic [dma_pkg::LEN_WIDTH-1:0]  pkt_sent_to_core_len,
  output logic [dma_pkg::ID_WIDTH-1:0]   awid,
  output logic [dma_pkg::ADDR_WIDTH-1:0] awaddr,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [dma_pkg::DATA_WIDTH-1:0] wdata,
  output logic                           wvalid,
  input  logic                           wready,
  input  logic                           bvalid,
  input  logic [1:0]                     bresp,
  output logic                           err_bresp
);

  import dma_pkg::*;

  trigger_t                   trig_in;
  trigger_t                   head;
  logic                       head_valid;
  logic                       launch;
  logic [CREDIT_WIDTH-1:0]    deliv_count;
  logic [CORE_ADDR_WIDTH-1:0] trig_local;
  logic [23:0]                slot_base;
  logic [7:0]                 slot_no_byte;

  assign trig_in = '{
    core_no:   trig.core_no,
    slot_no:   trig.slot_no,
    slot_addr: trig.slot_addr
  };

  // Sized for every slot the issuer can have in flight
  desc_fifo #(
    .item_t    (trigger_t),
    .DEPTH_LOG (TRIG_DEPTH_LOG)
  ) i_trig_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (trig.valid),
    .in_data   (trig_in),
    .in_ready  (),
    .out_valid (head_valid),
    .out_data  (head),
    .out_ready (launch)
  );

  assign launch = head_valid && !awvalid && !wvalid &&
                  (pkt_sent_to_core_valid || (deliv_count != '0));

  always_ff @(posedge clk) begin
    if (rst) begin
      deliv_count <= '0;
    end else if (pkt_sent_to_core_valid && !launch) begin
      deliv_count <= deliv_count + 1'b1;
    end else if (launch && !pkt_sent_to_core_valid) begin
      deliv_count <= deliv_count - 1'b1;
    end
  end

  // Trigger register of slot n sits at 0x100 + 8n
  assign trig_local   = 16'h0100 +
                        {{(CORE_ADDR_WIDTH-SLOT_NO_WIDTH-3){1'b0}}, head.slot_no, 3'b000};
  assign slot_base    = {{(24-SLOT_ADDR_EFF-SLOT_LEAD_ZERO){1'b0}}, head.slot_addr,
                         {SLOT_LEAD_ZERO{1'b0}}};
  assign slot_no_byte = {{(8-SLOT_NO_WIDTH){1'b0}}, head.slot_no};

  always_ff @(posedge clk) begin
    if (launch) begin
      awid   <= {{(ID_WIDTH-CORE_NO_WIDTH){1'b0}}, head.core_no};
      awaddr <= {head.core_no, trig_local};
      // Port field is always zero with a single MAC channel
      wdata  <= {8'd0, slot_base, slot_no_byte, 8'd0, pkt_sent_to_core_len};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      if (launch) begin
        awvalid <= 1'b1;
      end else if (awready) begin
        awvalid <= 1'b0;
      end
      if (launch) begin
        wvalid <= 1'b1;
      end else if (wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  // Tracks the most recent response only
  always_ff @(posedge clk) begin
    if (rst) begin
      err_bresp <= 1'b0;
    end else if (bvalid) begin
      err_bresp <= (bresp != 2'b00);
    end
  end

endmodule

// ==== desc_fifo.sv ====
module desc_fifo #(
  parameter type item_t    = logic [7:0],
  parameter int  DEPTH_LOG = 3
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  input  item_t in_data,
  output logic  in_ready,
  output logic  out_valid,
  output item_t out_data,
  input  logic  out_ready
);

  item_t mem [2**DEPTH_LOG];
  logic [DEPTH_LOG-1:0] wr_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr;
  logic [DEPTH_LOG:0]   count;
  logic                 push;
  logic                 pop;

  // Top count bit is set only when completely full
  assign in_ready  = !count[DEPTH_LOG];
  assign out_valid = |count;
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== dma_controller.f ====
dma_pkg.sv
desc_fifo.sv
trigger_if.sv
rx_desc_issuer.sv
core_trigger_writer.sv
tx_desc_decoder.sv
dma_controller.sv
tb_dma_controller.sv

// ==== dma_controller.sv ====
module dma_controller (
  input  logic                              clk,
  input  logic                              rst,

  // AXI write channels
  output logic [dma_pkg::ID_WIDTH-1:0]      awid,
  output logic [dma_pkg::ADDR_WIDTH-1:0]    awaddr,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [dma_pkg::DATA_WIDTH-1:0]    wdata,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic                              bvalid,
  input  logic [1:0]                        bresp,
  output logic                              bready,

  // DMA descriptors
  output logic [dma_pkg::ADDR_WIDTH-1:0]    rx_desc_addr,
  output logic [dma_pkg::LEN_WIDTH-1:0]     rx_desc_len,
  output logic                              rx_desc_valid,
  input  logic                              rx_desc_ready,
  output logic [dma_pkg::ADDR_WIDTH-1:0]    tx_desc_addr,
  output logic [dma_pkg::LEN_WIDTH-1:0]     tx_desc_len,
  output logic                              tx_desc_valid,
  input  logic                              tx_desc_ready,

  // Core messages
  input  logic [63:0]                       msg_data,
  input  logic [dma_pkg::CORE_NO_WIDTH-1:0] msg_core_no,
  input  logic                              msg_valid,
  output logic                              msg_ready,

  // MAC events
  input  logic                              incoming_pkt_ready,
  input  logic                              pkt_sent_to_core_valid,
  input  logic [dma_pkg::LEN_WIDTH-1:0]     pkt_sent_to_core_len,
  input  logic                              pkt_sent_out_valid,

  // Configuration
  input  logic [dma_pkg::CORE_COUNT-1:0]    drop_list,
  input  logic                              drop_list_valid,
  input  logic [dma_pkg::LEN_WIDTH-1:0]     max_pkt_len,
  input  logic                              max_pkt_len_valid,
  input  logic [dma_pkg::SLOT_NO_WIDTH-1:0] slot_addr_wr_no,
  input  logic [dma_pkg::SLOT_ADDR_EFF-1:0] slot_addr_wr_data,
  input  logic                              slot_addr_wr_valid,
  input  dma_pkg::slot_desc_t               inject_desc,
  input  logic                              inject_desc_valid,
  output logic                              inject_desc_ready,

  output logic                              err_bresp,
  output logic                              err_pool_overflow
);

  import dma_pkg::*;

  slot_desc_t return_desc;
  logic       return_valid;

  trigger_if trig ();

  assign bready = 1'b1;

  rx_desc_issuer i_rx_desc_issuer (
    .clk                (clk),
    .rst                (rst),
    .inject_desc        (inject_desc),
    .inject_desc_valid  (inject_desc_valid),
    .inject_desc_ready  (inject_desc_ready),
    .return_desc        (return_desc),
    .return_valid       (return_valid),
    .incoming_pkt_ready (incoming_pkt_ready),
    .drop_list          (drop_list),
    .drop_list_valid    (drop_list_valid),
    .max_pkt_len        (max_pkt_len),
    .max_pkt_len_valid  (max_pkt_len_valid),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_len        (rx_desc_len),
    .rx_desc_valid      (rx_desc_valid),
    .rx_desc_ready      (rx_desc_ready),
    .err_pool_overflow  (err_pool_overflow),
    .trig               (trig.issuer)
  );

  core_trigger_writer i_core_trigger_writer (
    .clk                    (clk),
    .rst                    (rst),
    .trig                   (trig.writer),
    .pkt_sent_to_core_valid (pkt_sent_to_core_valid),
    .pkt_sent_to_core_len   (pkt_sent_to_core_len),
    .awid                   (awid),
    .awaddr                 (awaddr),
    .awvalid                (awvalid),
    .awready                (awready),
    .wdata                  (wdata),
    .wvalid                 (wvalid),
    .wready                 (wready),
    .bvalid                 (bvalid),
    .bresp                  (bresp),
    .err_bresp              (err_bresp)
  );

  tx_desc_decoder i_tx_desc_decoder (
    .clk                (clk),
    .rst                (rst),
    .msg_data           (msg_data),
    .msg_core_no        (msg_core_no),
    .msg_valid          (msg_valid),
    .msg_ready          (msg_ready),
    .tx_desc_addr       (tx_desc_addr),
    .tx_desc_len        (tx_desc_len),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_ready      (tx_desc_ready),
    .pkt_sent_out_valid (pkt_sent_out_valid),
    .return_desc        (return_desc),
    .return_valid       (return_valid)
  );

endmodule

// ==== dma_pkg.sv ====
package dma_pkg;

  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 8;
  localparam int CORE_NO_WIDTH   = $clog2(CORE_COUNT);
  localparam int SLOT_NO_WIDTH   = $clog2(SLOT_COUNT);

  // Core-local address space, prefixed by the core number
  localparam int CORE_ADDR_WIDTH = 16;
  localparam int ADDR_WIDTH      = CORE_ADDR_WIDTH + CORE_NO_WIDTH;

  // Slot base addresses are 256-byte aligned
  localparam int SLOT_LEAD_ZERO  = 8;
  localparam int SLOT_ADDR_EFF   = 7;
  localparam logic [7:0] RX_WRITE_OFFSET = 8'h0A;

  localparam int LEN_WIDTH       = 16;
  localparam int DATA_WIDTH      = 64;
  localparam int ID_WIDTH        = 8;
  localparam logic [LEN_WIDTH-1:0] DEFAULT_MAX_LEN = 16'd1024;

  localparam int FREE_DEPTH_LOG  = $clog2(CORE_COUNT * SLOT_COUNT);
  localparam int TRIG_DEPTH_LOG  = $clog2(2 * CORE_COUNT);

  // Outstanding packet and delivery counters
  localparam int CREDIT_WIDTH    = 10;

  typedef struct packed {
    logic [CORE_NO_WIDTH-1:0] core_no;
    logic [SLOT_NO_WIDTH-1:0] slot_no;
  } slot_desc_t;

  typedef struct packed {
    logic [CORE_NO_WIDTH-1:0] core_no;
    logic [SLOT_NO_WIDTH-1:0] slot_no;
    logic [SLOT_ADDR_EFF-1:0] slot_addr;
  } trigger_t;

endpackage

// ==== rx_desc_issuer.sv ====
module rx_desc_issuer (
  input  logic                              clk,
  input  logic                              rst,
  input  dma_pkg::slot_desc_t               inject_desc,
  input  logic                              inject_desc_valid,
  output logic                              inject_desc_ready,
  input  dma_pkg::slot_desc_t               return_desc,
  input  logic                              return_valid,
  input  logic                              incoming_pkt_ready,
  input  logic [dma_pkg::CORE_COUNT-1:0]    drop_list,
  input  logic                              drop_list_valid,
  input  logic [dma_pkg::LEN_WIDTH-1:0]     max_pkt_len,
  input  logic                              max_pkt_len_valid,
  input  logic [dma_pkg::SLOT_NO_WIDTH-1:0] slot_addr_wr_no,
  input  logic [dma_pkg::SLOT_ADDR_EFF-1:0] slot_addr_wr_data,
  input  logic                              slot_addr_wr_valid,
  output logic [dma_pkg::ADDR_WIDTH-1:0]    rx_desc_addr,
  output logic [dma_pkg::LEN_WIDTH-1:0]     rx_desc_len,
  output logic                              rx_desc_valid,
  input  logic                              rx_desc_ready,
  output logic                              err_pool_overflow,
  trigger_if.issuer                         trig
);

  import dma_pkg::*;

  slot_desc_t               pool_in;
  logic                     pool_in_valid;
  logic                     pool_in_ready;
  slot_desc_t               head;
  logic                     head_valid;
  logic                     head_pop;

  logic [SLOT_ADDR_EFF-1:0] slot_addr_tbl [SLOT_COUNT];
  logic [CORE_COUNT-1:0]    drop_list_r;
  logic [LEN_WIDTH-1:0]     max_len_r;

  logic                     cand_valid;
  slot_desc_t               cand;
  logic [SLOT_ADDR_EFF-1:0] cand_addr;
  logic                     cand_drop;
  logic                     offer_ok;
  logic [CREDIT_WIDTH-1:0]  pkt_count;

  // Returned slots win over software injection
  assign pool_in           = return_valid ? return_desc : inject_desc;
  assign pool_in_valid     = return_valid || inject_desc_valid;
  assign inject_desc_ready = !return_valid && pool_in_ready;

  desc_fifo #(
    .item_t    (slot_desc_t),
    .DEPTH_LOG (FREE_DEPTH_LOG)
  ) i_free_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pool_in_valid),
    .in_data   (pool_in),
    .in_ready  (pool_in_ready),
    .out_valid (head_valid),
    .out_data  (head),
    .out_ready (head_pop)
  );

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      slot_addr_tbl[slot_addr_wr_no] <= slot_addr_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r       <= '0;
      max_len_r         <= DEFAULT_MAX_LEN;
      err_pool_overflow <= 1'b0;
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_r <= max_pkt_len;
      end
      if (return_valid && !pool_in_ready) begin
        err_pool_overflow <= 1'b1;
      end
    end
  end

  // Candidate stage; valid drops for a cycle after a pop so a stale head is never used
  always_ff @(posedge clk) begin
    if (rst) begin
      cand_valid <= 1'b0;
    end else begin
      cand_valid <= head_valid && !head_pop;
    end
  end

  always_ff @(posedge clk) begin
    cand      <= head;
    cand_addr <= slot_addr_tbl[head.slot_no];
  end

  assign cand_drop = drop_list_r[cand.core_no];
  assign offer_ok  = cand_valid && !cand_drop && rx_desc_ready;

  // Needs a packet announced now or one still waiting
  assign rx_desc_valid = offer_ok && (incoming_pkt_ready || (pkt_count != '0));
  assign head_pop      = (cand_valid && cand_drop) || rx_desc_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_count <= '0;
    end else if (incoming_pkt_ready && !rx_desc_valid) begin
      pkt_count <= pkt_count + 1'b1;
    end else if (rx_desc_valid && !incoming_pkt_ready) begin
      pkt_count <= pkt_count - 1'b1;
    end
  end

  assign rx_desc_addr = {cand.core_no, 1'b0, cand_addr, RX_WRITE_OFFSET};
  assign rx_desc_len  = max_len_r;

  assign trig.valid     = rx_desc_valid;
  assign trig.core_no   = cand.core_no;
  assign trig.slot_no   = cand.slot_no;
  assign trig.slot_addr = cand_addr;

endmodule

// ==== tb_dma_controller.sv ====
module tb_dma_controller;

  import dma_pkg::*;

  // Thirteen packets of a few dozen cycles each fit well inside this bound
  localparam int TIMEOUT_CYCLES = 4000;

  logic clk;
  logic rst;
  logic [ID_WIDTH-1:0] awid;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic [ADDR_WIDTH-1:0] rx_desc_addr;
  logic [LEN_WIDTH-1:0] rx_desc_len;
  logic rx_desc_valid;
  logic rx_desc_ready;
  logic [ADDR_WIDTH-1:0] tx_desc_addr;
  logic [LEN_WIDTH-1:0] tx_desc_len;
  logic tx_desc_valid;
  logic tx_desc_ready;
  logic [63:0] msg_data;
  logic [CORE_NO_WIDTH-1:0] msg_core_no;
  logic msg_valid;
  logic msg_ready;
  logic incoming_pkt_ready;
  logic pkt_sent_to_core_valid;
  logic [LEN_WIDTH-1:0] pkt_sent_to_core_len;
  logic pkt_sent_out_valid;
  logic [CORE_COUNT-1:0] drop_list;
  logic drop_list_valid;
  logic [LEN_WIDTH-1:0] max_pkt_len;
  logic max_pkt_len_valid;
  logic [SLOT_NO_WIDTH-1:0] slot_addr_wr_no;
  logic [SLOT_ADDR_EFF-1:0] slot_addr_wr_data;
  logic slot_addr_wr_valid;
  slot_desc_t inject_desc;
  logic inject_desc_valid;
  logic inject_desc_ready;
  logic err_bresp;
  logic err_pool_overflow;

  integer seed = 32'h010cec6c;
  logic stall_en;
  logic [1:0] resp_mode;
  logic exp_err;
  logic aw_wait;
  logic w_wait;
  logic [ADDR_WIDTH-1:0] aw_hold;
  logic [ID_WIDTH-1:0] id_hold;
  logic [DATA_WIDTH-1:0] w_hold;
  int rx_seen;
  int tx_seen;
  int b_seen;

  // Reference model state
  logic [SLOT_ADDR_EFF-1:0] addr_tbl [SLOT_COUNT];
  logic [CORE_COUNT-1:0] exp_drop;
  logic [LEN_WIDTH-1:0] exp_len;
  slot_desc_t exp_rx[$];
  trigger_t exp_aw[$];
  trigger_t exp_w[$];
  logic [LEN_WIDTH-1:0] exp_wlen[$];
  logic [ADDR_WIDTH-1:0] exp_tx_addr[$];
  logic [LEN_WIDTH-1:0] exp_tx_len[$];

  dma_controller i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the DUT stopped making progress");
    $display("*** FAILED ***");
    $fatal(1);
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAILED %s expected %h actual %h", name, exp, act);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [ADDR_WIDTH-1:0] rx_addr_of(input slot_desc_t d);
    return {d.core_no, 1'b0, addr_tbl[d.slot_no], 8'h0A};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] trig_addr_of(input trigger_t t);
    return {t.core_no, 16'h0100 + {10'd0, t.slot_no, 3'd0}};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] trig_data_of(input trigger_t t,
                                                          input logic [15:0] len);
    return {8'h00, 9'd0, t.slot_addr, 8'h00, 5'd0, t.slot_no, 8'h00, len};
  endfunction

  // AXI slave and descriptor sinks with random stalls
  always @(posedge clk) begin
    awready       <= stall_en ? (($random(seed) & 32'd3) != 0) : 1'b1;
    wready        <= stall_en ? (($random(seed) & 32'd3) != 0) : 1'b1;
    rx_desc_ready <= stall_en ? (($random(seed) & 32'd1) != 0) : 1'b1;
    tx_desc_ready <= stall_en ? (($random(seed) & 32'd3) != 0) : 1'b1;
    bvalid        <= wvalid && wready;
    bresp         <= (wvalid && wready) ? resp_mode : 2'b00;
  end

  always @(posedge clk) begin
    slot_desc_t d;
    trigger_t t;
    if (!rst) begin
      assert (err_pool_overflow == 1'b0) else report_error("free pool overflowed");
      assert (bready == 1'b1) else report_error("bready dropped");
      assert (err_bresp == exp_err) else report_mismatch("err_bresp", exp_err, err_bresp);
      assert (msg_ready == tx_desc_ready)
        else report_mismatch("msg_ready", tx_desc_ready, msg_ready);
      // Pool never fills here, so only a returning slot blocks injection
      assert (inject_desc_ready == !pkt_sent_out_valid)
        else report_mismatch("inject_desc_ready", !pkt_sent_out_valid, inject_desc_ready);
      if (aw_wait) begin
        assert (awvalid && awaddr == aw_hold) else report_mismatch("aw_stable", aw_hold, awaddr);
        assert (awid == id_hold) else report_mismatch("awid_stable", id_hold, awid);
      end
      if (w_wait) begin
        assert (wvalid && wdata == w_hold) else report_mismatch("w_stable", w_hold, wdata);
      end
      if (rx_desc_valid) begin
        assert (rx_desc_ready) else report_error("rx descriptor issued while not ready");
        assert (exp_rx.size() != 0) else report_error("unexpected rx descriptor");
        d = exp_rx.pop_front();
        assert (rx_desc_addr == rx_addr_of(d))
          else report_mismatch("rx_addr", rx_addr_of(d), rx_desc_addr);
        assert (rx_desc_len == exp_len) else report_mismatch("rx_len", exp_len, rx_desc_len);
        t = '{core_no: d.core_no, slot_no: d.slot_no, slot_addr: addr_tbl[d.slot_no]};
        exp_aw.push_back(t);
        exp_w.push_back(t);
        rx_seen <= rx_seen + 1;
      end
      if (awvalid && awready) begin
        assert (exp_aw.size() != 0) else report_error("unexpected AW beat");
        t = exp_aw.pop_front();
        assert (awaddr == trig_addr_of(t)) else report_mismatch("awaddr", trig_addr_of(t), awaddr);
        assert (awid == {6'd0, t.core_no}) else report_mismatch("awid", t.core_no, awid);
      end
      if (wvalid && wready) begin
        assert (exp_w.size() != 0 && exp_wlen.size() != 0)
          else report_error("unexpected W beat");
        t = exp_w.pop_front();
        assert (wdata == trig_data_of(t, exp_wlen[0]))
          else report_mismatch("wdata", trig_data_of(t, exp_wlen[0]), wdata);
        void'(exp_wlen.pop_front());
      end
      if (tx_desc_valid) begin
        assert (exp_tx_addr.size() != 0) else report_error("unexpected tx descriptor");
        assert (tx_desc_addr == exp_tx_addr[0])
          else report_mismatch("tx_addr", exp_tx_addr[0], tx_desc_addr);
        assert (tx_desc_len == exp_tx_len[0])
          else report_mismatch("tx_len", exp_tx_len[0], tx_desc_len);
        void'(exp_tx_addr.pop_front());
        void'(exp_tx_len.pop_front());
        tx_seen <= tx_seen + 1;
      end
      if (bvalid) begin
        exp_err <= (bresp != 2'b00);
        b_seen  <= b_seen + 1;
      end
    end
    aw_wait <= awvalid && !awready;
    aw_hold <= awaddr;
    id_hold <= awid;
    w_wait  <= wvalid && !wready;
    w_hold  <= wdata;
  end

  task automatic write_slot_addr(input int no, input logic [SLOT_ADDR_EFF-1:0] data);
    @(posedge clk);
    slot_addr_wr_no    <= SLOT_NO_WIDTH'(no);
    slot_addr_wr_data  <= data;
    slot_addr_wr_valid <= 1'b1;
    addr_tbl[no] = data;
    @(posedge clk);
    slot_addr_wr_valid <= 1'b0;
  endtask

  task automatic inject_slot(input int core, input int slot);
    slot_desc_t d;
    d = '{core_no: CORE_NO_WIDTH'(core), slot_no: SLOT_NO_WIDTH'(slot)};
    @(posedge clk);
    while (!inject_desc_ready) @(posedge clk);
    inject_desc       <= d;
    inject_desc_valid <= 1'b1;
    if (!exp_drop[core]) exp_rx.push_back(d);
    @(posedge clk);
    inject_desc_valid <= 1'b0;
  endtask

  // Announce one packet, wait for its descriptor, then report delivery
  task automatic serve_packet(input logic [LEN_WIDTH-1:0] len);
    int target;
    target = rx_seen + 1;
    @(posedge clk);
    incoming_pkt_ready <= 1'b1;
    @(posedge clk);
    incoming_pkt_ready <= 1'b0;
    while (rx_seen < target) @(posedge clk);
    @(posedge clk);
    while (awvalid || wvalid) @(posedge clk);
    pkt_sent_to_core_valid <= 1'b1;
    pkt_sent_to_core_len   <= len;
    exp_wlen.push_back(len);
    @(posedge clk);
    pkt_sent_to_core_valid <= 1'b0;
  endtask

  // Message stays valid until the decoder takes it
  task automatic send_msg(input int core, input int slot, input logic [15:0] local_addr,
                          input logic [15:0] len);
    @(posedge clk);
    msg_core_no <= CORE_NO_WIDTH'(core);
    msg_data    <= {16'h0000, local_addr, 5'd0, 3'(slot), 8'h00, len};
    msg_valid   <= 1'b1;
    if (len != 16'd0) begin
      exp_tx_addr.push_back({2'(core), local_addr});
      exp_tx_len.push_back(len);
    end
    @(posedge clk);
    while (!msg_ready) @(posedge clk);
    msg_valid <= 1'b0;
  endtask

  // Transmit one packet and return its slot to the pool
  task automatic transmit(input int core, input int slot, input logic [15:0] local_addr,
                          input logic [15:0] len);
    int target;
    slot_desc_t d;
    target = tx_seen + 1;
    d = '{core_no: CORE_NO_WIDTH'(core), slot_no: SLOT_NO_WIDTH'(slot)};
    send_msg(core, slot, local_addr, len);
    while (tx_seen < target) @(posedge clk);
    @(posedge clk);
    pkt_sent_out_valid <= 1'b1;
    exp_rx.push_back(d);
    @(posedge clk);
    pkt_sent_out_valid <= 1'b0;
  endtask

  task automatic wait_responses(input int target);
    while (b_seen < target) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    rst = 1'b1;
    awready = 1'b1;
    wready = 1'b1;
    bvalid = 1'b0;
    bresp = 2'b00;
    rx_desc_ready = 1'b1;
    tx_desc_ready = 1'b1;
    msg_data = '0;
    msg_core_no = '0;
    msg_valid = 1'b0;
    incoming_pkt_ready = 1'b0;
    pkt_sent_to_core_valid = 1'b0;
    pkt_sent_to_core_len = '0;
    pkt_sent_out_valid = 1'b0;
    drop_list = '0;
    drop_list_valid = 1'b0;
    max_pkt_len = '0;
    max_pkt_len_valid = 1'b0;
    slot_addr_wr_no = '0;
    slot_addr_wr_data = '0;
    slot_addr_wr_valid = 1'b0;
    inject_desc = '0;
    inject_desc_valid = 1'b0;
    stall_en = 1'b0;
    resp_mode = 2'b00;
    exp_err = 1'b0;
    aw_wait = 1'b0;
    w_wait = 1'b0;
    rx_seen = 0;
    tx_seen = 0;
    b_seen = 0;
    exp_drop = '0;
    exp_len = DEFAULT_MAX_LEN;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Receive descriptors, with a max length change halfway
    for (int i = 0; i < SLOT_COUNT; i++) write_slot_addr(i, 7'((i * 13 + 5) & 32'h7f));
    stall_en <= 1'b1;
    inject_slot(0, 0);
    inject_slot(1, 1);
    inject_slot(2, 2);
    inject_slot(3, 3);
    inject_slot(0, 4);
    inject_slot(1, 5);
    serve_packet(16'd64);
    serve_packet(16'd200);
    serve_packet(16'd1000);
    @(posedge clk);
    max_pkt_len       <= 16'd512;
    max_pkt_len_valid <= 1'b1;
    exp_len = 16'd512;
    @(posedge clk);
    max_pkt_len_valid <= 1'b0;
    serve_packet(16'd77);
    serve_packet(16'd512);
    serve_packet(16'd1);

    // Drop list holds core 2
    @(posedge clk);
    drop_list       <= 4'b0100;
    drop_list_valid <= 1'b1;
    exp_drop = 4'b0100;
    @(posedge clk);
    drop_list_valid <= 1'b0;
    inject_slot(2, 0);
    inject_slot(3, 1);
    inject_slot(2, 6);
    inject_slot(0, 7);
    inject_slot(1, 2);
    serve_packet(16'd300);
    serve_packet(16'd301);
    serve_packet(16'd302);

    // Transmit descriptors and slot recycling
    transmit(1, 5, 16'h2340, 16'd60);
    send_msg(3, 1, 16'h0800, 16'd0);
    repeat (4) @(posedge clk);
    transmit(0, 7, 16'h9a00, 16'd1500);
    serve_packet(16'd88);
    serve_packet(16'd99);

    // Write response error and recovery
    inject_slot(3, 4);
    inject_slot(0, 1);
    wait_responses(rx_seen);
    resp_mode <= 2'b10;
    serve_packet(16'd40);
    wait_responses(rx_seen);
    assert (err_bresp == 1'b1) else report_mismatch("err_bresp_set", 1, err_bresp);
    resp_mode <= 2'b00;
    serve_packet(16'd41);
    wait_responses(rx_seen);
    assert (err_bresp == 1'b0) else report_mismatch("err_bresp_clear", 0, err_bresp);

    repeat (10) @(posedge clk);
    if (exp_rx.size() != 0 || exp_aw.size() != 0 || exp_w.size() != 0 ||
        exp_tx_addr.size() != 0) begin
      $display("Error: expected transfers never appeared");
      $display("*** FAILED ***");
      $fatal(1);
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== trigger_if.sv ====
interface trigger_if;

  import dma_pkg::*;

  logic                     valid;
  logic [CORE_NO_WIDTH-1:0] core_no;
  logic [SLOT_NO_WIDTH-1:0] slot_no;
  logic [SLOT_ADDR_EFF-1:0] slot_addr;

  modport issuer (
    output valid, core_no, slot_no, slot_addr
  );

  modport writer (
    input valid, core_no, slot_no, slot_addr
  );

endinterface

// ==== tx_desc_decoder.sv ====
module tx_desc_decoder (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [63:0]                       msg_data,
  input  logic [dma_pkg::CORE_NO_WIDTH-1:0] msg_core_no,
  input  logic                              msg_valid,
  output logic                              msg_ready,
  output logic [dma_pkg::ADDR_WIDTH-1:0]    tx_desc_addr,
  output logic [dma_pkg::LEN_WIDTH-1:0]     tx_desc_len,
  output logic                              tx_desc_valid,
  input  logic                              tx_desc_ready,
  input  logic                              pkt_sent_out_valid,
  output dma_pkg::slot_desc_t               return_desc,
  output logic                              return_valid
);

  import dma_pkg::*;

  logic                       accept;
  logic [LEN_WIDTH-1:0]       msg_len;
  logic [SLOT_NO_WIDTH-1:0]   msg_slot_no;
  logic [CORE_ADDR_WIDTH-1:0] msg_local_addr;
  slot_desc_t                 pend_slot;
  slot_desc_t                 sent_slot;

  assign msg_ready      = tx_desc_ready;
  assign accept         = msg_valid && msg_ready;
  assign msg_len        = msg_data[15:0];
  assign msg_slot_no    = msg_data[24 +: SLOT_NO_WIDTH];
  assign msg_local_addr = msg_data[32 +: CORE_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_desc_valid <= 1'b0;
    end else begin
      // Zero length means the core dropped the packet
      tx_desc_valid <= accept && (msg_len != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tx_desc_addr      <= {msg_core_no, msg_local_addr};
      tx_desc_len       <= msg_len;
      pend_slot.core_no <= msg_core_no;
      pend_slot.slot_no <= msg_slot_no;
    end
  end

  // Slot of the packet now handed to the MAC
  always_ff @(posedge clk) begin
    if (tx_desc_valid) begin
      sent_slot <= pend_slot;
    end
  end

  assign return_desc  = sent_slot;
  assign return_valid = pkt_sent_out_valid;

endmodule
